// File: files.f
+incdir+.
fetch_pkg.sv
mem_pkg.sv
pc_gen.sv
icache_ram.sv
icache.sv
fetch_queue.sv
fetch_unit.sv
tb_fetch_unit.sv

// File: Makefile
TOP = tb_fetch_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ns -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f files.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_unit
    import fetch_pkg::*;
    import mem_pkg::*;
;

    localparam int ROW_TIMEOUT  = 3000;   // cycles allowed per row
    localparam int QUIET_CYCLES = 40;

    typedef struct packed {
        logic [31:0] pc;
        logic [7:0]  count;      // pairs to take
        logic [7:0]  mask;       // out_ready pattern, one bit per cycle
        logic        rnd;        // random out_ready instead of mask
        logic        err_en;
        logic [31:0] err_addr;
    } row_t;

    logic        clk;
    logic        rst;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    fetch_pair_t out_pair;
    logic        out_valid;
    logic        out_ready;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;

    row_t        rows [$];
    int          errors;
    int          checks;
    logic        err_enable;
    logic [31:0] err_addr;
    logic [31:0] wait_lfsr;
    logic [31:0] stall_lfsr;
    logic [1:0]  wait_left;

    fetch_unit fetch_unit_i (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .out_pair       (out_pair),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
        begin
            n = n ^ 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
        end
        return n;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return a ^ 32'h5a5a_0000;
    endfunction

    // first pair whose pc or pc + 4 lies in the line of the error word
    function automatic int first_fault_pair(input logic [31:0] p, input logic [31:0] e);
        int          k;
        logic [31:0] a;
        for (k = 0; k < 256; k++)
        begin
            a = p + 32'(8 * k);
            if (a[31:4] == e[31:4] || (a + 32'd4) >> 4 == e >> 4)
            begin
                return k;
            end
        end
        return -1;
    endfunction

    task automatic add_row(input logic [31:0] pc, input int count, input logic [7:0] mask,
                           input logic rnd, input logic err_en, input logic [31:0] err_a);
        row_t r;
        r.pc       = pc;
        r.count    = 8'(count);
        r.mask     = mask;
        r.rnd      = rnd;
        r.err_en   = err_en;
        r.err_addr = err_a;
        rows.push_back(r);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic expect_quiet(input int cycles);
        int   n;
        logic seen;
        seen      = 1'b0;
        out_ready = 1'b1;
        for (n = 0; n < cycles; n++)
        begin
            @(negedge clk);
            if (out_valid && !seen)
            begin
                seen = 1'b1;
                errors++;
                $display("a pair was delivered after a fault, before any redirect");
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_row(input row_t r, input int idx);
        int          k;
        int          cyc;
        int          fk;
        int          err_before;
        logic [2:0]  phase;
        logic [31:0] exp_pc;
        logic        exp_fault;
        err_before = errors;
        fk         = r.err_en ? first_fault_pair(r.pc, r.err_addr) : -1;
        err_enable = r.err_en;
        err_addr   = r.err_addr;
        redirect_valid = 1'b1;
        redirect_pc    = r.pc;
        out_ready      = 1'b0;
        @(posedge clk);
        #1;
        redirect_valid = 1'b0;
        k     = 0;
        cyc   = 0;
        phase = 3'd0;
        while (k < int'(r.count) && cyc < ROW_TIMEOUT)
        begin
            if (r.rnd)
            begin
                out_ready  = stall_lfsr[0];
                stall_lfsr = lfsr_next(stall_lfsr);
            end
            else
            begin
                out_ready = r.mask[phase];
            end
            @(negedge clk);
            if (out_valid && out_ready)
            begin
                exp_pc    = r.pc + 32'(8 * k);
                exp_fault = (k == fk);
                compare_value("out_pair.pc", out_pair.pc, exp_pc);
                compare_value("out_pair.inst0", out_pair.inst0,
                              exp_fault ? 32'd0 : mem_word(exp_pc));
                compare_value("out_pair.inst1", out_pair.inst1,
                              exp_fault ? 32'd0 : mem_word(exp_pc + 32'd4));
                compare_value("out_pair.fault", {31'd0, out_pair.fault}, {31'd0, exp_fault});
                k++;
            end
            @(posedge clk);
            #1;
            cyc++;
            phase = phase + 3'd1;
        end
        if (k < int'(r.count))
        begin
            errors++;
            $display("row %0d timed out with %0d of %0d pairs received", idx, k, r.count);
        end
        else if (fk >= 0)
        begin
            expect_quiet(QUIET_CYCLES);
        end
        $display("row %0d pc %h: %0d pairs, %0d errors", idx, r.pc, k, errors - err_before);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // APB memory, random wait states per transfer
    initial
    begin
        apb_rsp   = '0;
        wait_lfsr = 32'ha2b5;
        wait_left = 2'd0;
        forever
        begin
            @(posedge clk);
            #1;
            if (rst || !apb_req.psel)
            begin
                apb_rsp = '0;
            end
            else if (!apb_req.penable)
            begin
                compare_value("apb_req.pwrite", {31'd0, apb_req.pwrite}, 32'd0);
                apb_rsp      = '0;   // setup cycle
                wait_left[0] = wait_lfsr[0];
                wait_lfsr    = lfsr_next(wait_lfsr);
                wait_left[1] = wait_lfsr[0];
                wait_lfsr    = lfsr_next(wait_lfsr);
            end
            else if (wait_left != 2'd0)
            begin
                apb_rsp.pready = 1'b0;
                wait_left      = wait_left - 2'd1;
            end
            else
            begin
                apb_rsp.pready  = 1'b1;
                apb_rsp.prdata  = mem_word(apb_req.paddr);
                apb_rsp.pslverr = err_enable && (apb_req.paddr == err_addr);
            end
        end
    end

    initial
    begin
        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = 32'd0;
        out_ready      = 1'b0;
        err_enable     = 1'b0;
        err_addr       = 32'd0;
        errors         = 0;
        checks         = 0;
        stall_lfsr     = 32'ha2b5;
        add_row(32'h0000_0000, 12, 8'hff, 1'b0, 1'b0, 32'h0);   // cold stream
        add_row(32'h0000_0000, 12, 8'hff, 1'b0, 1'b0, 32'h0);   // same region, hits
        add_row(32'h0000_020c, 4,  8'hff, 1'b0, 1'b0, 32'h0);   // pair spans two lines
        add_row(32'h0000_1050, 2,  8'hff, 1'b0, 1'b0, 32'h0);   // three tags in set 5
        add_row(32'h0000_1450, 2,  8'hff, 1'b0, 1'b0, 32'h0);
        add_row(32'h0000_1850, 2,  8'hff, 1'b0, 1'b0, 32'h0);
        add_row(32'h0000_1050, 2,  8'hff, 1'b0, 1'b0, 32'h0);
        add_row(32'h0000_1450, 2,  8'hff, 1'b0, 1'b0, 32'h0);
        add_row(32'h0000_3000, 24, 8'hff, 1'b1, 1'b0, 32'h0);   // random stalls
        add_row(32'h0000_0040, 8,  8'h91, 1'b0, 1'b0, 32'h0);   // fixed stall pattern
        add_row(32'h0000_2000, 5,  8'hff, 1'b0, 1'b1, 32'h0000_2020);
        add_row(32'h0000_2000, 8,  8'hff, 1'b0, 1'b0, 32'h0);   // recovery
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (rows[i])
        begin
            run_row(rows[i], i);
        end
        $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
        if (errors == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_cfg.svh"

module fetch_unit
    import fetch_pkg::*;
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    output fetch_pair_t out_pair,
    output logic        out_valid,
    input  logic        out_ready,
    output apb_req_t    apb_req,
    input  apb_rsp_t    apb_rsp
);

    fetch_req_t  req;
    fetch_pair_t pair;
    logic        ready;
    logic        push;
    logic        full;
    logic        fault_seen;

    pc_gen pc_gen_i (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fault_seen     (fault_seen),
        .req            (req),
        .ready          (ready)
    );

    icache icache_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (redirect_valid),
        .req        (req),
        .ready      (ready),
        .pair       (pair),
        .push       (push),
        .full       (full),
        .fault_seen (fault_seen),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp)
    );

    fetch_queue #(
        .DEPTH (`FETCH_QUEUE_DEPTH),
        .T     (fetch_pair_t)
    ) fetch_queue_i (
        .clk       (clk),
        .rst       (rst),
        .flush     (redirect_valid),
        .in_data   (pair),
        .push      (push),
        .full      (full),
        .out_data  (out_pair),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// File: fetch_queue.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_cfg.svh"

module fetch_queue
    import fetch_pkg::*;
#(
    parameter int  DEPTH = `FETCH_QUEUE_DEPTH,
    parameter type T     = fetch_pair_t
)
(
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  T     in_data,
    input  logic push,
    output logic full,
    output T     out_data,
    output logic out_valid,
    input  logic out_ready
);

    localparam int PTR_W = $clog2(DEPTH);

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    T               mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic [PTR_W:0]   count_next;
    logic             pop;

    assign pop      = out_valid && out_ready;
    assign out_data = mem[rd_ptr];

    always_comb
    begin
        count_next = count;
        if (push)
        begin
            count_next = count_next + 1'b1;
        end
        if (pop)
        begin
            count_next = count_next - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
            full      <= 1'b0;
        end
        else
        begin
            count     <= count_next;
            out_valid <= count_next != '0;
            full      <= count_next == (PTR_W+1)'(DEPTH);
            if (push)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= in_data;
        end
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (rst) !(push && full));

endmodule

`default_nettype wire

// File: icache.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_cfg.svh"

module icache
    import fetch_pkg::*;
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  fetch_req_t  req,
    output logic        ready,
    output fetch_pair_t pair,
    output logic        push,
    input  logic        full,
    output logic        fault_seen,
    output apb_req_t    apb_req,
    input  apb_rsp_t    apb_rsp
);

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        SETTLE
    } refill_state_t;

    function automatic logic [IDX_W-1:0] index_of(input logic [31:0] a);
        return a[OFS_W +: IDX_W];
    endfunction

    function automatic logic [TAG_W-1:0] tag_of(input logic [31:0] a);
        return a[31 -: TAG_W];
    endfunction

    refill_state_t           state;
    logic                    s2_valid;
    logic [31:0]             s2_pc;
    logic [31:0]             s2_pc1;
    logic [31:0]             rd_pc;
    logic [31:0]             rd_pc1;
    logic [31:0]             refill_addr;
    logic [IDX_W-1:0]        refill_index;
    logic [WORD_W-1:0]       word_cnt;
    line_data_t              line_buf;
    logic [`ICACHE_SETS-1:0] lru;   // 1 means way1 is next victim
    logic                    abort;
    logic                    fault_pending;
    cache_line_t             r0_w0, r1_w0, r0_w1, r1_w1;
    cache_line_t             w_line;
    logic                    we0, we1;
    logic                    hit0_w0, hit0_w1, hit1_w0, hit1_w1;
    logic                    hit0, hit1, hit_pair;
    logic                    idle, miss, xfer_done, fill_done;
    logic [31:0]             inst0, inst1;

    assign s2_pc1 = s2_pc + 32'd4;
    assign rd_pc  = ready ? req.pc : s2_pc;   // keep stage 2 lines on the ram outputs
    assign rd_pc1 = rd_pc + 32'd4;
    assign refill_index = index_of(refill_addr);

    icache_ram way0 (
        .clk      (clk),
        .rst      (rst),
        .we       (we0),
        .w_index  (refill_index),
        .w_line   (w_line),
        .r_index0 (index_of(rd_pc)),
        .r_index1 (index_of(rd_pc1)),
        .r_line0  (r0_w0),
        .r_line1  (r1_w0)
    );

    icache_ram way1 (
        .clk      (clk),
        .rst      (rst),
        .we       (we1),
        .w_index  (refill_index),
        .w_line   (w_line),
        .r_index0 (index_of(rd_pc)),
        .r_index1 (index_of(rd_pc1)),
        .r_line0  (r0_w1),
        .r_line1  (r1_w1)
    );

    assign hit0_w0  = r0_w0.valid && (r0_w0.tag == tag_of(s2_pc));
    assign hit0_w1  = r0_w1.valid && (r0_w1.tag == tag_of(s2_pc));
    assign hit1_w0  = r1_w0.valid && (r1_w0.tag == tag_of(s2_pc1));
    assign hit1_w1  = r1_w1.valid && (r1_w1.tag == tag_of(s2_pc1));
    assign hit0     = hit0_w0 | hit0_w1;
    assign hit1     = hit1_w0 | hit1_w1;
    assign hit_pair = hit0 & hit1;

    assign inst0 = hit0_w0 ? r0_w0.data[s2_pc[2 +: WORD_W]] : r0_w1.data[s2_pc[2 +: WORD_W]];
    assign inst1 = hit1_w0 ? r1_w0.data[s2_pc1[2 +: WORD_W]] : r1_w1.data[s2_pc1[2 +: WORD_W]];

    assign idle       = state == IDLE;
    assign push       = idle && s2_valid && (hit_pair || fault_pending) && !full && !flush;
    assign fault_seen = push && fault_pending;
    assign ready      = idle && !fault_pending && !flush && (!s2_valid || (hit_pair && !full));
    assign miss       = idle && s2_valid && !hit_pair && !fault_pending && !flush;

    always_comb
    begin
        pair.pc    = s2_pc;
        pair.fault = fault_pending;
        pair.inst0 = fault_pending ? 32'd0 : inst0;
        pair.inst1 = fault_pending ? 32'd0 : inst1;
    end

    assign xfer_done = (state == ACCESS) && apb_rsp.pready;
    assign fill_done = xfer_done && !apb_rsp.pslverr && !abort && !flush
                       && (word_cnt == WORD_W'(`LINE_WORDS - 1));

    always_comb
    begin
        w_line.valid = 1'b1;
        w_line.tag   = tag_of(refill_addr);
        w_line.data  = line_buf;
        w_line.data[`LINE_WORDS-1] = apb_rsp.prdata;   // last beat goes straight in
    end

    assign we0 = fill_done && !lru[refill_index];
    assign we1 = fill_done && lru[refill_index];

    always_comb
    begin
        apb_req.paddr   = {refill_addr[31:OFS_W], word_cnt, 2'b00};
        apb_req.psel    = (state == SETUP) || (state == ACCESS);
        apb_req.penable = state == ACCESS;
        apb_req.pwrite  = 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s2_valid <= 1'b0;
        end
        else if (flush)
        begin
            s2_valid <= 1'b0;
        end
        else if (ready)
        begin
            s2_valid <= req.valid;
        end
        else if (push)
        begin
            s2_valid <= 1'b0;   // faulted pair leaves
        end
    end

    always_ff @(posedge clk)
    begin
        if (ready)
        begin
            s2_pc <= req.pc;
        end
        if (miss)
        begin
            refill_addr <= hit0 ? s2_pc1 : s2_pc;   // first missing line
        end
        if (xfer_done)
        begin
            line_buf[word_cnt] <= apb_rsp.prdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state         <= IDLE;
            word_cnt      <= '0;
            abort         <= 1'b0;
            fault_pending <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (miss)
                    begin
                        state    <= SETUP;
                        word_cnt <= '0;
                    end
                SETUP:
                    state <= ACCESS;
                ACCESS:
                    if (apb_rsp.pready)
                    begin
                        if (abort || flush)
                        begin
                            state <= IDLE;
                        end
                        else if (apb_rsp.pslverr)
                        begin
                            state         <= IDLE;
                            fault_pending <= 1'b1;
                        end
                        else if (fill_done)
                        begin
                            state <= SETTLE;
                        end
                        else
                        begin
                            state    <= SETUP;
                            word_cnt <= word_cnt + 1'b1;
                        end
                    end
                default:
                    state <= IDLE;   // ram read picks up the new line
            endcase
            if (xfer_done)
            begin
                abort <= 1'b0;
            end
            else if (flush && apb_req.psel)
            begin
                abort <= 1'b1;   // finish this beat, then drop the refill
            end
            if (flush || fault_seen)
            begin
                fault_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            lru <= '0;
        end
        else if (fill_done)
        begin
            lru[refill_index] <= !lru[refill_index];
        end
        else if (push && !fault_pending)
        begin
            lru[index_of(s2_pc)]  <= hit0_w0;   // hit in way0 makes way1 the victim
            lru[index_of(s2_pc1)] <= hit1_w0;
        end
    end

    penable_needs_psel: assert property (@(posedge clk) disable iff (rst)
        apb_req.penable |-> apb_req.psel && $past(apb_req.psel));

    paddr_stable: assert property (@(posedge clk) disable iff (rst)
        apb_req.psel && !(apb_req.penable && apb_rsp.pready) |=> $stable(apb_req.paddr));

endmodule

`default_nettype wire

// File: icache_ram.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_cfg.svh"

module icache_ram
    import mem_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             we,
    input  logic [IDX_W-1:0] w_index,
    input  cache_line_t      w_line,
    input  logic [IDX_W-1:0] r_index0,
    input  logic [IDX_W-1:0] r_index1,
    output cache_line_t      r_line0,
    output cache_line_t      r_line1
);

    logic [`ICACHE_SETS-1:0] valid;
    logic [TAG_W-1:0]        tag_mem  [`ICACHE_SETS];
    line_data_t              data_mem [`ICACHE_SETS];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid <= '0;
        end
        else if (we)
        begin
            valid[w_index] <= w_line.valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            tag_mem[w_index]  <= w_line.tag;
            data_mem[w_index] <= w_line.data;
        end
        // same-index write shows up one cycle later
        r_line0.valid <= valid[r_index0];
        r_line0.tag   <= tag_mem[r_index0];
        r_line0.data  <= data_mem[r_index0];
        r_line1.valid <= valid[r_index1];
        r_line1.tag   <= tag_mem[r_index1];
        r_line1.data  <= data_mem[r_index1];
    end

endmodule

`default_nettype wire

// File: pc_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_cfg.svh"

module pc_gen
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    input  logic        fault_seen,
    output fetch_req_t  req,
    input  logic        ready
);

    logic [31:0] pc;
    logic        running;
    logic        halted;   // set by a fault, cleared by redirect

    assign req.valid = running;
    assign req.pc    = pc;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc      <= `RESET_PC;
            running <= 1'b0;
            halted  <= 1'b0;
        end
        else if (redirect_valid)
        begin
            pc      <= redirect_pc;
            running <= 1'b1;
            halted  <= 1'b0;
        end
        else
        begin
            halted  <= halted | fault_seen;
            running <= !halted && !fault_seen;
            if (req.valid && ready)
            begin
                pc <= pc + 32'd8;   // two instructions per fetch
            end
        end
    end

    pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: mem_pkg.sv
`default_nettype none

`include "icache_cfg.svh"

package mem_pkg;

    localparam int WORD_W = $clog2(`LINE_WORDS);    // word select within a line
    localparam int OFS_W  = WORD_W + 2;              // byte offset bits
    localparam int IDX_W  = $clog2(`ICACHE_SETS);
    localparam int TAG_W  = 32 - IDX_W - OFS_W;

    typedef logic [`LINE_WORDS-1:0][31:0] line_data_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        line_data_t       data;
    } cache_line_t;

    typedef struct packed {
        logic [31:0] paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// File: fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } fetch_req_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst0;   // word at pc
        logic [31:0] inst1;   // word at pc + 4
        logic        fault;   // refill saw pslverr
    } fetch_pair_t;

endpackage

`default_nettype wire

// File: icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// cache geometry
`define ICACHE_SETS 64
`define LINE_WORDS 4

// fetch queue entries
`define FETCH_QUEUE_DEPTH 4

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif
